// File: filelist.f
rtl/asg_pkg.sv
rtl/asg_regs.sv
rtl/asg_pointer.sv
rtl/asg_table.sv
rtl/asg_scale.sv
rtl/asg_top.sv
test/asg_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the waveform generator testbench with Verilator and run it.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

if ! verilator --binary --assert -Wno-fatal \
    --top-module asg_tb -f filelist.f -o asg_sim; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/asg_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TESTS PASSED" sim.log; then
  echo "run.sh: pass line found in sim.log"
  exit 0
fi

echo "run.sh: pass line missing from sim.log"
exit 1

// File: test/asg_tb.sv
// testbench for the one channel waveform generator
// random table and settings from a fixed seed
// every output beat checked against a model
// wrap-mode streams are stopped over the bus and the model queue is flushed after the drain
// evn_per is matched per beat only while out_ready stays high
module asg_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import asg_pkg::*;

  localparam int unsigned SEED       = 32'haa65_04c3;
  localparam int          MAX_CYCLES = 20000;  // table fill ~3k, streams ~3k, x2 margin

  typedef struct packed {
    sample_t data;
    logic    last;
    logic    wrap;  // pointer wrapped on this beat
  } beat_s;

  // dut signals
  logic       bus = 1'b0;
  logic       rst_n;
  axi_addr_t  awaddr;
  logic       awvalid;
  logic       awready;
  axi_data_t  wdata;
  logic       wvalid;
  logic       wready;
  logic       bvalid;
  logic       bready;
  axi_resp_t  bresp;
  axi_addr_t  araddr;
  logic       arvalid;
  logic       arready;
  logic       rvalid;
  logic       rready;
  axi_data_t  rdata;
  axi_resp_t  rresp;
  evn_mask_t  evn_ext;
  sample_t    out_data;
  logic       out_valid;
  logic       out_ready;
  logic       evn_per;
  logic       evn_lst;

  // model state
  sample_t    tbl_model [TBL_DEPTH];
  int         m_size;
  int         m_offs;
  int         m_step;
  logic       m_wrap;
  gain_t      m_gain;
  sample_t    m_sum;
  beat_s      exp_q [$];   // beats still to come
  int         rx_cnt;
  string      cur_test;
  logic       chk_per;
  logic       bp_en;
  logic [2:0] per_d;       // evn_per lined up with the output stage
  int         cyc;

  asg_top uut (.*);

  always #4 bus = ~bus;  // 8 ns

  //////////////////////////////
  // checks
  //////////////////////////////
  task automatic fail_now(string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_word(string name, axi_data_t exp, axi_data_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_sample(string name, sample_t exp, sample_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "sample mismatch");
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("ERROR %s: expected %0b, actual %0b", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic check_resp(string name, axi_resp_t exp, axi_resp_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "response mismatch");
    end
  endtask

  always @(posedge bus) begin
    cyc++;
    if (cyc >= MAX_CYCLES) begin
      $display("timeout: tests did not finish within %0d clock cycles", MAX_CYCLES);
      $display("TESTS FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  // random sink stalls while bp_en is set
  always @(posedge bus) begin
    if (bp_en) out_ready <= ($urandom_range(0, 1) == 1);
    else       out_ready <= 1'b1;
  end

  // sampler takes one model beat per accepted output beat
  always @(posedge bus) begin
    beat_s b;
    if (rst_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        fail_now($sformatf("%s: sample %0d arrived while none was expected", cur_test, out_data));
      end else begin
        b = exp_q.pop_front();
        check_sample({cur_test, " out_data"}, b.data, out_data);
        check_flag({cur_test, " evn_lst"}, b.last, evn_lst);
        if (chk_per) check_flag({cur_test, " evn_per"}, b.wrap, per_d[2]);
        rx_cnt++;
      end
    end else if (chk_per && per_d[2]) begin
      fail_now($sformatf("%s: evn_per pulsed with no output beat to match", cur_test));
    end
    per_d = {per_d[1:0], evn_per};  // pointer stage is 3 beats ahead
  end

  //////////////////////////////
  // axi4-lite driver
  //////////////////////////////
  task automatic axi_write(axi_addr_t a, axi_data_t d);
    @(posedge bus);
    awaddr  <= a;
    wdata   <= d;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    @(posedge bus);
    while (!awready) @(posedge bus);
    check_flag({cur_test, " wready"}, 1'b1, wready);  // aw and w taken together
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(posedge bus);
    while (!bvalid) @(posedge bus);  // bready held high
    check_resp({cur_test, " bresp"}, RESP_OKAY, bresp);
  endtask

  task automatic axi_read(axi_addr_t a, output axi_data_t d);
    @(posedge bus);
    araddr  <= a;
    arvalid <= 1'b1;
    @(posedge bus);
    while (!arready) @(posedge bus);
    arvalid <= 1'b0;
    @(posedge bus);
    while (!rvalid) @(posedge bus);
    check_resp({cur_test, " rresp"}, RESP_OKAY, rresp);
    d = rdata;
  endtask

  //////////////////////////////
  // model
  //////////////////////////////
  // floor shift by 14, add, clamp to 14 bit signed
  function automatic sample_t scale_model(sample_t s, gain_t g, sample_t o);
    int p;
    int v;
    p = int'(s) * int'(g);
    v = (p >>> GAIN_FRAC) + int'(o);
    if (v > (1 << (SAMPLE_W - 1)) - 1) v = (1 << (SAMPLE_W - 1)) - 1;
    else if (v < -(1 << (SAMPLE_W - 1))) v = -(1 << (SAMPLE_W - 1));
    return sample_t'(v);
  endfunction

  task automatic build_model(int max_beats);
    int    p;
    int    nx;
    beat_s b;
    exp_q.delete();
    p = m_offs;
    for (int k = 0; k < max_beats; k++) begin
      nx     = p + m_step;
      b.data = scale_model(tbl_model[p >> PTR_FRAC], m_gain, m_sum);
      b.wrap = m_wrap && (nx >= m_size);
      b.last = !m_wrap && (nx >= m_size);  // one-shot end
      exp_q.push_back(b);
      if (b.last) break;
      p = (nx >= m_size) ? nx - m_size : nx;  // fraction kept over wrap
    end
  endtask

  task automatic fill_table();
    axi_data_t d;
    cur_test = "table_fill";
    for (int i = 0; i < TBL_DEPTH; i++) begin
      d            = $urandom;
      tbl_model[i] = sample_t'(d);
      axi_write(axi_addr_t'((1 << TBL_SEL_BIT) | (i << 2)), d);
    end
  endtask

  // whole-entry size, offset below size, odd step so the fraction is nonzero
  task automatic set_pointer(logic wrap);
    m_size = int'((16 + $urandom % (TBL_DEPTH - 16)) << PTR_FRAC);
    m_offs = int'($urandom % m_size);
    m_step = int'(((1 << PTR_FRAC) + $urandom % (2 << PTR_FRAC)) | 1);
    m_wrap = wrap;
    axi_write(REG_SIZE, axi_data_t'(m_size));
    axi_write(REG_OFFS, axi_data_t'(m_offs));
    axi_write(REG_STEP, axi_data_t'(m_step));
    axi_write(REG_MODE, axi_data_t'(wrap));
  endtask

  task automatic set_scale(gain_t g, sample_t s);
    m_gain = g;
    m_sum  = s;
    axi_write(REG_GAIN, axi_data_t'(g));
    axi_write(REG_SUM, axi_data_t'(s));
  endtask

  task automatic wait_rx(int n);
    while (rx_cnt < n) @(negedge bus);
  endtask

  task automatic pulse_event(evn_mask_t m);
    @(posedge bus);
    evn_ext <= m;
    @(posedge bus);
    evn_ext <= '0;
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////
  task automatic test_regs();
    axi_addr_t a;
    int        w;
    axi_data_t d;
    axi_data_t rd;
    cur_test = "reg_readback";
    axi_read(REG_CTL, rd);
    check_flag("reg_readback running after reset", 1'b0, rd[0]);
    for (int k = 0; k < 9; k++) begin
      case (k)
        0:       begin a = REG_MSK_STR; w = EVN_W;    end
        1:       begin a = REG_MSK_STP; w = EVN_W;    end
        2:       begin a = REG_MSK_TRG; w = EVN_W;    end
        3:       begin a = REG_SIZE;    w = PTR_W;    end
        4:       begin a = REG_OFFS;    w = PTR_W;    end
        5:       begin a = REG_STEP;    w = PTR_W;    end
        6:       begin a = REG_MODE;    w = 1;        end
        7:       begin a = REG_GAIN;    w = GAIN_W;   end
        default: begin a = REG_SUM;     w = SAMPLE_W; end
      endcase
      d = $urandom;
      axi_write(a, d);
      axi_read(a, rd);
      check_word($sformatf("reg_readback 0x%03h", a), d & axi_data_t'((64'd1 << w) - 1), rd);
    end
    axi_read(axi_addr_t'(12'h040), rd);  // unmapped
    check_word("reg_readback unmapped", '0, rd);
    axi_read(axi_addr_t'(1 << TBL_SEL_BIT), rd);  // table is write-only
    check_word("reg_readback table", '0, rd);
  endtask

  // start, collect n beats, stop, let the tail drain
  task automatic run_wrap(string name, int n, logic bp);
    cur_test = name;
    chk_per  = !bp;
    build_model(n + 32);
    rx_cnt   = 0;
    bp_en   <= bp;
    axi_write(REG_CTL, 32'h2);
    wait_rx(n);
    bp_en   <= 1'b0;
    axi_write(REG_CTL, 32'h4);
    repeat (12) @(posedge bus);
    exp_q.delete();
  endtask

  task automatic test_one_shot();
    axi_data_t rd;
    int        n;
    cur_test = "one_shot";
    chk_per  = 1'b1;
    set_pointer(1'b0);
    build_model(TBL_DEPTH + 1);
    n      = exp_q.size();
    rx_cnt = 0;
    axi_write(REG_CTL, 32'h2);
    wait_rx(n);
    repeat (10) @(posedge bus);  // an extra beat trips the sampler
    axi_read(REG_CTL, rd);
    check_flag("one_shot running after pass", 1'b0, rd[0]);
  endtask

  task automatic test_scale();
    gain_t   g;
    sample_t s;
    set_pointer(1'b1);
    for (int k = 0; k < 5; k++) begin
      case (k)
        0:       begin g = 16'sh7fff; s = 14'sh1fff; end  // both at max
        1:       begin g = 16'sh8000; s = 14'sh2000; end  // both at min
        2:       begin g = 16'sh8000; s = 14'sh1fff; end
        default: begin g = gain_t'($urandom); s = sample_t'($urandom); end
      endcase
      set_scale(g, s);
      run_wrap($sformatf("gain_offset_%0d", k), 120, 1'b0);
    end
  endtask

  task automatic test_events();
    axi_data_t rd;
    int        snap;
    cur_test = "ext_event";
    chk_per  = 1'b1;
    set_pointer(1'b1);
    axi_write(REG_MSK_STR, 32'h2);  // line 1
    axi_write(REG_MSK_STP, 32'h4);  // line 2
    axi_write(REG_MSK_TRG, 32'h0);
    exp_q.delete();
    rx_cnt = 0;
    pulse_event(4'b1000);  // line 3 is in no mask
    repeat (10) @(posedge bus);
    @(negedge bus);
    check_word("ext_event unmasked sample count", '0, axi_data_t'(rx_cnt));
    axi_read(REG_CTL, rd);
    check_flag("ext_event unmasked running", 1'b0, rd[0]);
    build_model(80);
    pulse_event(4'b0010);
    wait_rx(40);
    pulse_event(4'b0100);
    @(negedge bus);
    snap = rx_cnt;
    repeat (10) @(posedge bus);
    @(negedge bus);
    if (rx_cnt - snap > 3) begin
      fail_now($sformatf("ext_event: %0d samples after the stop event, more than 3 in flight",
                         rx_cnt - snap));
    end
    exp_q.delete();
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n     = 1'b0;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wvalid    = 1'b0;
    bready    = 1'b1;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b1;
    evn_ext   = '0;
    out_ready = 1'b1;
    bp_en     = 1'b0;
    chk_per   = 1'b0;
    per_d     = '0;
    rx_cnt    = 0;
    cyc       = 0;
    cur_test  = "reset";
    repeat (8) @(posedge bus);
    rst_n <= 1'b1;
    repeat (2) @(posedge bus);

    test_regs();
    fill_table();
    set_pointer(1'b1);
    set_scale(16'sd16384, '0);  // unity gain
    run_wrap("wrap_mode", 300, 1'b0);
    test_one_shot();
    test_scale();
    set_pointer(1'b1);
    set_scale(gain_t'($urandom), sample_t'($urandom));
    run_wrap("back_pressure", 300, 1'b1);
    test_events();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: rtl/asg_top.sv
// one channel waveform generator top
// register block feeds pointer -> table -> gain -> offset pipeline
// evn_ext must already be synchronous to the bus clock
module asg_top (
  input  logic                bus,
  input  logic                rst_n,
  // axi4-lite slave
  input  asg_pkg::axi_addr_t  awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  asg_pkg::axi_data_t  wdata,
  input  logic                wvalid,
  output logic                wready,
  output logic                bvalid,
  input  logic                bready,
  output asg_pkg::axi_resp_t  bresp,
  input  asg_pkg::axi_addr_t  araddr,
  input  logic                arvalid,
  output logic                arready,
  output logic                rvalid,
  input  logic                rready,
  output asg_pkg::axi_data_t  rdata,
  output asg_pkg::axi_resp_t  rresp,
  // events and sample stream
  input  asg_pkg::evn_mask_t  evn_ext,
  output asg_pkg::sample_t    out_data,
  output logic                out_valid,
  input  logic                out_ready,
  output logic                evn_per,
  output logic                evn_lst
);
  import asg_pkg::*;

  asg_cfg_s  cfg;
  asg_ctl_s  ctl;
  tbl_wr_s   tbl_wr;
  ptr_addr_s ptr_addr;   // stage 1 -> 2
  stage_s    tbl_stage;  // stage 2 -> 3
  logic      rdy_ptr;    // table ready toward pointer
  logic      rdy_tbl;    // scale ready toward table
  logic      running;

  asg_regs u_regs (
    .bus, .rst_n,
    .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
    .bvalid, .bready, .bresp,
    .araddr, .arvalid, .arready, .rvalid, .rready, .rdata, .rresp,
    .evn_ext, .running, .cfg, .ctl, .tbl_wr
  );

  asg_pointer u_pointer (
    .bus, .rst_n, .cfg, .ctl,
    .ready    (rdy_ptr),
    .addr_out (ptr_addr),
    .running, .evn_per
  );

  asg_table u_table (
    .bus, .rst_n, .tbl_wr,
    .addr_in   (ptr_addr),
    .ready     (rdy_tbl),
    .stage_out (tbl_stage),
    .ready_up  (rdy_ptr)
  );

  asg_scale u_scale (
    .bus, .rst_n,
    .stage_in (tbl_stage),
    .gain     (cfg.gain),
    .sum      (cfg.sum),
    .out_ready,
    .ready_up (rdy_tbl),
    .out_data, .out_valid, .evn_lst
  );

endmodule

// File: rtl/asg_scale.sv
// gain and offset, pipeline stages 3 and 4
// stage 3: sample * gain, then >>> GAIN_FRAC (floor)
// stage 4: + sum, saturated to the 14 bit signed range
// gain and sum are sampled when a sample enters each stage
module asg_scale (
  input  logic              bus,
  input  logic              rst_n,
  input  asg_pkg::stage_s   stage_in,
  input  asg_pkg::gain_t    gain,
  input  asg_pkg::sample_t  sum,
  input  logic              out_ready,
  output logic              ready_up,
  output asg_pkg::sample_t  out_data,
  output logic              out_valid,
  output logic              evn_lst
);
  import asg_pkg::*;

  logic signed [MUL_W-1:0] prod;
  logic signed [MUL_W-GAIN_FRAC:0] add;  // one bit of headroom
  scl_t    s3_data;
  logic    s3_vld;
  logic    s3_last;
  logic    ld3;
  logic    ld4;
  sample_t sat;

  assign ld4      = !out_valid || out_ready;
  assign ld3      = !s3_vld || ld4;
  assign ready_up = ld3;

  //////////////////////////////
  // stage 3, multiply
  //////////////////////////////
  assign prod = stage_in.data * gain;  // 14x16 signed

  always_ff @(posedge bus) begin
    if (ld3) s3_data <= prod[MUL_W-1:GAIN_FRAC];  // slice = floor shift
  end

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      s3_vld  <= 1'b0;
      s3_last <= 1'b0;
    end else if (ld3) begin
      s3_vld  <= stage_in.valid;
      s3_last <= stage_in.valid && stage_in.last;
    end
  end

  //////////////////////////////
  // stage 4, offset + saturate
  //////////////////////////////
  assign add = s3_data + sum;  // both sign extended

  always_comb begin
    // fits when bits above the sample msb all copy the sign
    if (add[MUL_W-GAIN_FRAC:SAMPLE_W-1] == '0 || add[MUL_W-GAIN_FRAC:SAMPLE_W-1] == '1) begin
      sat = add[SAMPLE_W-1:0];
    end else if (add[MUL_W-GAIN_FRAC]) begin
      sat = {1'b1, {(SAMPLE_W-1){1'b0}}};  // most negative
    end else begin
      sat = {1'b0, {(SAMPLE_W-1){1'b1}}};  // most positive
    end
  end

  always_ff @(posedge bus) begin
    if (ld4) out_data <= sat;
  end

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      evn_lst   <= 1'b0;
    end else if (ld4) begin
      out_valid <= s3_vld;
      evn_lst   <= s3_vld && s3_last;  // rides the final one-shot beat
    end
  end

  // stream data held while the sink stalls
  a_out_stable: assert property (@(posedge bus) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// File: rtl/asg_table.sv
// sample table, pipeline stage 2
// 1024 x 14 bit ram, bus write port and one registered read port
// the read register only updates when the stage may load
module asg_table (
  input  logic                bus,
  input  logic                rst_n,
  input  asg_pkg::tbl_wr_s    tbl_wr,
  input  asg_pkg::ptr_addr_s  addr_in,
  input  logic                ready,
  output asg_pkg::stage_s     stage_out,
  output logic                ready_up
);
  import asg_pkg::*;

  sample_t mem [TBL_DEPTH];
  sample_t data_q;
  logic    vld_q;
  logic    last_q;
  logic    ld;

  // load when empty or downstream takes the current sample
  assign ld       = !vld_q || ready;
  assign ready_up = ld;

  //////////////////////////////
  // bus write port
  //////////////////////////////
  always_ff @(posedge bus) begin
    if (tbl_wr.en) mem[tbl_wr.addr] <= tbl_wr.data;
  end

  //////////////////////////////
  // pipeline read
  //////////////////////////////
  always_ff @(posedge bus) begin
    if (ld) data_q <= mem[addr_in.addr];  // read enable = ld
  end

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      vld_q  <= 1'b0;
      last_q <= 1'b0;
    end else if (ld) begin
      vld_q  <= addr_in.valid;
      last_q <= addr_in.valid && addr_in.last;
    end
  end

  assign stage_out.valid = vld_q;
  assign stage_out.data  = data_q;
  assign stage_out.last  = last_q;

endmodule

// File: rtl/asg_pointer.sv
// read pointer, pipeline stage 1, 10.16 fixed point
// offset must lie below size, size is meant in whole table entries
// start and trigger both restart at offset, stop and ptr_rst end the run
// back-pressure freezes the pointer together with its output register
module asg_pointer (
  input  logic                bus,
  input  logic                rst_n,
  input  asg_pkg::asg_cfg_s   cfg,
  input  asg_pkg::asg_ctl_s   ctl,
  input  logic                ready,
  output asg_pkg::ptr_addr_s  addr_out,
  output logic                running,
  output logic                evn_per
);
  import asg_pkg::*;

  ptr_state_e       state;
  ptr_t             ptr;
  ptr_t             cur;       // pointer issued this cycle
  logic [PTR_W:0]   nxt;       // spare bit for carry
  logic [PTR_W:0]   nxt_wrap;
  logic             ld;        // output register may take a beat
  logic             go;
  logic             active;
  logic             hit;       // next pointer reaches size

  assign ld       = !addr_out.valid || ready;
  assign go       = ctl.start | ctl.trigger;
  assign active   = go || (state == RUN);
  assign cur      = go ? cfg.offs : ptr;
  assign nxt      = {1'b0, cur} + {1'b0, cfg.step};
  assign hit      = nxt >= {1'b0, cfg.size};
  assign nxt_wrap = nxt - {1'b0, cfg.size};
  assign running  = (state == RUN);

  //////////////////////////////
  // fsm and pointer
  //////////////////////////////
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      ptr      <= '0;
      addr_out <= '0;
      evn_per  <= 1'b0;
    end else begin
      evn_per <= 1'b0;
      if (ctl.ptr_rst || ctl.stop) begin
        // empty this stage only, later stages drain
        state          <= IDLE;
        addr_out.valid <= 1'b0;
        addr_out.last  <= 1'b0;
        if (ctl.ptr_rst) ptr <= '0;
      end else if (active && ld) begin
        addr_out.valid <= 1'b1;
        addr_out.addr  <= cur[PTR_W-1:PTR_FRAC];  // integer part
        addr_out.last  <= hit && !cfg.wrap;
        if (!hit) begin
          ptr   <= nxt[PTR_W-1:0];
          state <= RUN;
        end else if (cfg.wrap) begin
          ptr     <= nxt_wrap[PTR_W-1:0];  // keep fraction across wrap
          evn_per <= 1'b1;
          state   <= RUN;
        end else begin
          ptr   <= nxt[PTR_W-1:0];
          state <= IDLE;  // one-shot done
        end
      end else begin
        if (ld) begin
          addr_out.valid <= 1'b0;
          addr_out.last  <= 1'b0;
        end
        // start while stalled, first beat goes out once unblocked
        if (go) begin
          ptr   <= cfg.offs;
          state <= RUN;
        end
      end
    end
  end

  // index checked against size, which covers wrap and one-shot end
  a_idx_in_range: assert property (@(posedge bus) disable iff (!rst_n)
    addr_out.valid |-> ({addr_out.addr, {PTR_FRAC{1'b0}}} < cfg.size));

endmodule

// File: rtl/asg_regs.sv
// axi4-lite slave for the generator registers and the write-only sample table
// one outstanding write and one outstanding read, write strobes ignored
// addr bit 12 set selects the table, word index in bits 11:2
// table and unmapped reads return zero, every response is OKAY
module asg_regs (
  input  logic                 bus,
  input  logic                 rst_n,
  // axi4-lite
  input  asg_pkg::axi_addr_t   awaddr,
  input  logic                 awvalid,
  output logic                 awready,
  input  asg_pkg::axi_data_t   wdata,
  input  logic                 wvalid,
  output logic                 wready,
  output logic                 bvalid,
  input  logic                 bready,
  output asg_pkg::axi_resp_t   bresp,
  input  asg_pkg::axi_addr_t   araddr,
  input  logic                 arvalid,
  output logic                 arready,
  output logic                 rvalid,
  input  logic                 rready,
  output asg_pkg::axi_data_t   rdata,
  output asg_pkg::axi_resp_t   rresp,
  // generator side
  input  asg_pkg::evn_mask_t   evn_ext,
  input  logic                 running,
  output asg_pkg::asg_cfg_s    cfg,
  output asg_pkg::asg_ctl_s    ctl,
  output asg_pkg::tbl_wr_s     tbl_wr
);
  import asg_pkg::*;

  logic      wr_acc;   // aw and w taken together
  logic      rd_acc;
  logic      wr_reg;   // write hits register region
  reg_addr_t wa;
  reg_addr_t ra;
  asg_ctl_s  sw_ctl;   // software pulses, one cycle
  axi_data_t rd_val;

  //////////////////////////////
  // handshakes
  //////////////////////////////
  assign wr_acc  = awvalid & wvalid & ~bvalid;
  assign rd_acc  = arvalid & ~rvalid;
  assign awready = wr_acc;
  assign wready  = wr_acc;
  assign arready = rd_acc;
  assign bresp   = RESP_OKAY;
  assign rresp   = RESP_OKAY;

  assign wa     = awaddr[TBL_SEL_BIT-1:0];
  assign ra     = araddr[TBL_SEL_BIT-1:0];
  assign wr_reg = wr_acc & ~awaddr[TBL_SEL_BIT];

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (wr_acc)      bvalid <= 1'b1;
      else if (bready) bvalid <= 1'b0;
      if (rd_acc)      rvalid <= 1'b1;
      else if (rready) rvalid <= 1'b0;
    end
  end

  //////////////////////////////
  // configuration
  //////////////////////////////
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      cfg      <= '0;
      cfg.wrap <= 1'b1;  // wrap mode by default
      sw_ctl   <= '0;
    end else begin
      sw_ctl <= '0;  // pulses last one cycle
      if (wr_reg) begin
        case (wa)
          REG_CTL:     sw_ctl      <= asg_ctl_s'(wdata[3:0]);
          REG_MSK_STR: cfg.msk_str <= wdata[EVN_W-1:0];
          REG_MSK_STP: cfg.msk_stp <= wdata[EVN_W-1:0];
          REG_MSK_TRG: cfg.msk_trg <= wdata[EVN_W-1:0];
          REG_SIZE:    cfg.size    <= wdata[PTR_W-1:0];
          REG_OFFS:    cfg.offs    <= wdata[PTR_W-1:0];
          REG_STEP:    cfg.step    <= wdata[PTR_W-1:0];
          REG_MODE:    cfg.wrap    <= wdata[0];
          REG_GAIN:    cfg.gain    <= wdata[GAIN_W-1:0];
          REG_SUM:     cfg.sum     <= wdata[SAMPLE_W-1:0];
          default: ;   // unmapped, dropped
        endcase
      end
    end
  end

  // sw pulses are a cycle late, ext events act in the same cycle
  always_comb begin
    ctl.ptr_rst = sw_ctl.ptr_rst;
    ctl.start   = sw_ctl.start   | (|(evn_ext & cfg.msk_str));
    ctl.stop    = sw_ctl.stop    | (|(evn_ext & cfg.msk_stp));
    ctl.trigger = sw_ctl.trigger | (|(evn_ext & cfg.msk_trg));
  end

  // table write goes straight through, no response wait
  assign tbl_wr.en   = wr_acc & awaddr[TBL_SEL_BIT];
  assign tbl_wr.addr = awaddr[TBL_SEL_BIT-1:2];
  assign tbl_wr.data = wdata[SAMPLE_W-1:0];

  //////////////////////////////
  // read path
  //////////////////////////////
  always_comb begin
    rd_val = '0;
    if (!araddr[TBL_SEL_BIT]) begin
      case (ra)
        REG_CTL:     rd_val[0]            = running;
        REG_MSK_STR: rd_val[EVN_W-1:0]    = cfg.msk_str;
        REG_MSK_STP: rd_val[EVN_W-1:0]    = cfg.msk_stp;
        REG_MSK_TRG: rd_val[EVN_W-1:0]    = cfg.msk_trg;
        REG_SIZE:    rd_val[PTR_W-1:0]    = cfg.size;
        REG_OFFS:    rd_val[PTR_W-1:0]    = cfg.offs;
        REG_STEP:    rd_val[PTR_W-1:0]    = cfg.step;
        REG_MODE:    rd_val[0]            = cfg.wrap;
        REG_GAIN:    rd_val[GAIN_W-1:0]   = cfg.gain;    // raw bits, no sign ext
        REG_SUM:     rd_val[SAMPLE_W-1:0] = cfg.sum;
        default: ;
      endcase
    end
  end

  always_ff @(posedge bus) begin
    if (rd_acc) rdata <= rd_val;
  end

  // write response held until the master takes it
  a_bvalid_hold: assert property (@(posedge bus) disable iff (!rst_n)
    bvalid && !bready |=> bvalid);

endmodule

// File: rtl/asg_pkg.sv
// shared widths, register map and stage payloads for the waveform generator
// pointer is 10.16 fixed point, the integer part indexes the 1024-entry table
// gain is signed 2.14, so 16384 is unity gain
package asg_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////
  localparam int SAMPLE_W  = 14;           // dac sample
  localparam int TBL_AW    = 10;
  localparam int TBL_DEPTH = 1 << TBL_AW;  // 1024 entries
  localparam int PTR_FRAC  = 16;
  localparam int PTR_W     = TBL_AW + PTR_FRAC;  // 26
  localparam int GAIN_W    = 16;
  localparam int GAIN_FRAC = 14;
  localparam int MUL_W     = SAMPLE_W + GAIN_W;  // full product
  localparam int EVN_W     = 4;

  // axi4-lite
  localparam int TBL_SEL_BIT = 12;  // table vs register region
  localparam int AXI_AW      = TBL_SEL_BIT + 1;
  localparam int AXI_DW      = 32;

  typedef logic signed [SAMPLE_W-1:0]          sample_t;
  typedef logic        [TBL_AW-1:0]            tbl_addr_t;
  typedef logic        [PTR_W-1:0]             ptr_t;
  typedef logic signed [GAIN_W-1:0]            gain_t;
  typedef logic signed [MUL_W-GAIN_FRAC-1:0]   scl_t;  // product after shift
  typedef logic        [EVN_W-1:0]             evn_mask_t;
  typedef logic        [AXI_AW-1:0]            axi_addr_t;
  typedef logic        [AXI_DW-1:0]            axi_data_t;
  typedef logic        [1:0]                   axi_resp_t;
  typedef logic        [TBL_SEL_BIT-1:0]       reg_addr_t;

  localparam axi_resp_t RESP_OKAY = 2'b00;

  //////////////////////////////
  // register map, byte addresses
  //////////////////////////////
  localparam reg_addr_t REG_CTL     = 12'h000;  // wr pulses, rd running
  localparam reg_addr_t REG_MSK_STR = 12'h004;
  localparam reg_addr_t REG_MSK_STP = 12'h008;
  localparam reg_addr_t REG_MSK_TRG = 12'h00C;
  localparam reg_addr_t REG_SIZE    = 12'h010;
  localparam reg_addr_t REG_OFFS    = 12'h014;
  localparam reg_addr_t REG_STEP    = 12'h018;
  localparam reg_addr_t REG_MODE    = 12'h01C;  // bit0 wrap
  localparam reg_addr_t REG_GAIN    = 12'h020;
  localparam reg_addr_t REG_SUM     = 12'h024;

  typedef enum logic {IDLE, RUN} ptr_state_e;

  typedef struct packed {
    ptr_t      size;
    ptr_t      offs;
    ptr_t      step;
    logic      wrap;
    gain_t     gain;
    sample_t   sum;
    evn_mask_t msk_str;
    evn_mask_t msk_stp;
    evn_mask_t msk_trg;
  } asg_cfg_s;

  // field order matches REG_CTL write bits, ptr_rst is bit0
  typedef struct packed {
    logic trigger;
    logic stop;
    logic start;
    logic ptr_rst;
  } asg_ctl_s;

  typedef struct packed {
    logic      en;
    tbl_addr_t addr;
    sample_t   data;
  } tbl_wr_s;

  // pointer stage output
  typedef struct packed {
    logic      valid;
    tbl_addr_t addr;
    logic      last;
  } ptr_addr_s;

  typedef struct packed {
    logic    valid;
    sample_t data;
    logic    last;
  } stage_s;

endpackage
